//--- lsu_router.sv
`timescale 1ns/1ps

`include "mem_region_settings.svh"

module lsu_router (
  input  logic                     clk,
  input  logic                     rst_n,

  // from the load/store unit
  input  logic                     lsu_req_i,
  input  mem_region_pkg::mem_req_t lsu_i,
  output logic                     lsu_gnt_o,
  output mem_region_pkg::mem_rsp_t lsu_rsp_o,

  // to the data bank
  output logic                     ram_req_o,
  output mem_region_pkg::mem_req_t ram_o,
  input  logic                     ram_gnt_i,
  input  mem_region_pkg::mem_rsp_t ram_rsp_i,

  // to the external region
  output logic                     ext_req_o,
  output mem_region_pkg::mem_req_t ext_o,
  input  logic                     ext_gnt_i,
  input  mem_region_pkg::mem_rsp_t ext_rsp_i
);

  logic                     is_ext;
  mem_region_pkg::rsp_src_e src_q;
  mem_region_pkg::rsp_src_e src_d;

  // request side
  assign is_ext = |lsu_i.addr[`MR_EXT_MSB:`MR_EXT_LSB];

  always_comb
  begin
    ram_req_o = lsu_req_i & ~is_ext;
    ext_req_o = lsu_req_i & is_ext;
    ram_o     = lsu_i;
    ext_o     = lsu_i;
  end

  // grant comes from whichever target is addressed
  always_comb
  begin
    src_d     = src_q;
    lsu_gnt_o = 1'b0;
    if (ext_req_o)
    begin
      lsu_gnt_o = ext_gnt_i;
      src_d     = mem_region_pkg::SRC_EXT;
    end
    else if (ram_req_o)
    begin
      lsu_gnt_o = ram_gnt_i;
      src_d     = mem_region_pkg::SRC_RAM;
    end
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      src_q <= mem_region_pkg::SRC_RAM;
    end
    else
    begin
      src_q <= src_d;
    end
  end

  // response side
  always_comb
  begin
    case (src_q)
      mem_region_pkg::SRC_EXT:
      begin
        lsu_rsp_o = ext_rsp_i;
      end
      default:
      begin
        lsu_rsp_o = ram_rsp_i;
      end
    endcase
  end

  // only one response outstanding across a region switch
  rsp_exclusive_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    !(ram_rsp_i.rvalid && ext_rsp_i.rvalid)
  ) else $error("data RAM and external responses in the same cycle");

endmodule

//--- mem_bank.sv
`timescale 1ns/1ps

`include "mem_region_settings.svh"

module mem_bank (
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic                     p0_req_i,
  input  mem_region_pkg::mem_req_t p0_i,
  output logic                     p0_gnt_o,
  output mem_region_pkg::mem_rsp_t p0_rsp_o,

  input  logic                     p1_req_i,
  input  mem_region_pkg::mem_req_t p1_i,
  output logic                     p1_gnt_o,
  output mem_region_pkg::mem_rsp_t p1_rsp_o
);

  logic                      ram_en;
  mem_region_pkg::mem_req_t  ram_req;
  logic [`MR_DATA_WIDTH-1:0] ram_rdata;

  ram_arbiter u_ram_arbiter (
    .clk         ( clk       ),
    .rst_n       ( rst_n     ),
    .p0_req_i    ( p0_req_i  ),
    .p0_i        ( p0_i      ),
    .p0_gnt_o    ( p0_gnt_o  ),
    .p0_rsp_o    ( p0_rsp_o  ),
    .p1_req_i    ( p1_req_i  ),
    .p1_i        ( p1_i      ),
    .p1_gnt_o    ( p1_gnt_o  ),
    .p1_rsp_o    ( p1_rsp_o  ),
    .ram_en_o    ( ram_en    ),
    .ram_o       ( ram_req   ),
    .ram_rdata_i ( ram_rdata )
  );

  // word index only, upper address bits wrap
  sp_ram u_sp_ram (
    .clk     ( clk                                    ),
    .en_i    ( ram_en                                 ),
    .addr_i  ( ram_req.addr[`MR_RAM_ADDR_WIDTH+1:2]   ),
    .we_i    ( ram_req.we                             ),
    .be_i    ( ram_req.be                             ),
    .wdata_i ( ram_req.wdata                          ),
    .rdata_o ( ram_rdata                              )
  );

endmodule

//--- mem_region.f
+incdir+.
mem_region_pkg.sv
sp_ram.sv
ram_arbiter.sv
mem_bank.sv
lsu_router.sv
mem_region_top.sv
tb_mem_region.sv

//--- mem_region_pkg.sv
`include "mem_region_settings.svh"

package mem_region_pkg;

  // one request on a req/gnt/rvalid port
  typedef struct packed {
    logic [`MR_ADDR_WIDTH-1:0] addr;
    logic                      we;
    logic [`MR_BE_WIDTH-1:0]   be;
    logic [`MR_DATA_WIDTH-1:0] wdata;
  } mem_req_t;

  // rdata only meaningful on a read response
  typedef struct packed {
    logic                      rvalid;
    logic [`MR_DATA_WIDTH-1:0] rdata;
  } mem_rsp_t;

  // where the next lsu response comes from
  typedef enum logic [0:0] {
    SRC_EXT = 1'b0,
    SRC_RAM = 1'b1
  } rsp_src_e;

endpackage

//--- mem_region_settings.svh
`ifndef MR_SETTINGS_SVH
`define MR_SETTINGS_SVH

// byte address and data word
`define MR_ADDR_WIDTH      32
`define MR_DATA_WIDTH      32
`define MR_BE_WIDTH        4

// word index bits of each local RAM
`define MR_RAM_ADDR_WIDTH  10

// nonzero value in these address bits selects the external region
`define MR_EXT_MSB         31
`define MR_EXT_LSB         24

`endif

//--- mem_region_top.sv
`timescale 1ns/1ps

module mem_region_top (
  input  logic                     clk,
  input  logic                     rst_n,

  // instruction fetch
  input  logic                     fetch_req_i,
  input  mem_region_pkg::mem_req_t fetch_i,
  output logic                     fetch_gnt_o,
  output mem_region_pkg::mem_rsp_t fetch_rsp_o,

  // load/store
  input  logic                     lsu_req_i,
  input  mem_region_pkg::mem_req_t lsu_i,
  output logic                     lsu_gnt_o,
  output mem_region_pkg::mem_rsp_t lsu_rsp_o,

  // instruction loader
  input  logic                     iload_req_i,
  input  mem_region_pkg::mem_req_t iload_i,
  output logic                     iload_gnt_o,
  output mem_region_pkg::mem_rsp_t iload_rsp_o,

  // data loader
  input  logic                     dload_req_i,
  input  mem_region_pkg::mem_req_t dload_i,
  output logic                     dload_gnt_o,
  output mem_region_pkg::mem_rsp_t dload_rsp_o,

  // external region
  output logic                     ext_req_o,
  output mem_region_pkg::mem_req_t ext_o,
  input  logic                     ext_gnt_i,
  input  mem_region_pkg::mem_rsp_t ext_rsp_i
);

  mem_region_pkg::mem_req_t fetch_req;

  logic                     data_req;
  mem_region_pkg::mem_req_t data_req_s;
  logic                     data_gnt;
  mem_region_pkg::mem_rsp_t data_rsp;

  // fetch is always a full word read
  always_comb
  begin
    fetch_req       = fetch_i;
    fetch_req.we    = 1'b0;
    fetch_req.be    = '1;
    fetch_req.wdata = '0;
  end

  lsu_router u_lsu_router (
    .clk       ( clk        ),
    .rst_n     ( rst_n      ),
    .lsu_req_i ( lsu_req_i  ),
    .lsu_i     ( lsu_i      ),
    .lsu_gnt_o ( lsu_gnt_o  ),
    .lsu_rsp_o ( lsu_rsp_o  ),
    .ram_req_o ( data_req   ),
    .ram_o     ( data_req_s ),
    .ram_gnt_i ( data_gnt   ),
    .ram_rsp_i ( data_rsp   ),
    .ext_req_o ( ext_req_o  ),
    .ext_o     ( ext_o      ),
    .ext_gnt_i ( ext_gnt_i  ),
    .ext_rsp_i ( ext_rsp_i  )
  );

  mem_bank u_instr_bank (
    .clk      ( clk         ),
    .rst_n    ( rst_n       ),
    .p0_req_i ( iload_req_i ),
    .p0_i     ( iload_i     ),
    .p0_gnt_o ( iload_gnt_o ),
    .p0_rsp_o ( iload_rsp_o ),
    .p1_req_i ( fetch_req_i ),
    .p1_i     ( fetch_req   ),
    .p1_gnt_o ( fetch_gnt_o ),
    .p1_rsp_o ( fetch_rsp_o )
  );

  mem_bank u_data_bank (
    .clk      ( clk         ),
    .rst_n    ( rst_n       ),
    .p0_req_i ( dload_req_i ),
    .p0_i     ( dload_i     ),
    .p0_gnt_o ( dload_gnt_o ),
    .p0_rsp_o ( dload_rsp_o ),
    .p1_req_i ( data_req    ),
    .p1_i     ( data_req_s  ),
    .p1_gnt_o ( data_gnt    ),
    .p1_rsp_o ( data_rsp    )
  );

endmodule

//--- ram_arbiter.sv
`timescale 1ns/1ps

`include "mem_region_settings.svh"

module ram_arbiter (
  input  logic                      clk,
  input  logic                      rst_n,

  // port 0 is the loader
  input  logic                      p0_req_i,
  input  mem_region_pkg::mem_req_t  p0_i,
  output logic                      p0_gnt_o,
  output mem_region_pkg::mem_rsp_t  p0_rsp_o,

  // port 1 is the core side
  input  logic                      p1_req_i,
  input  mem_region_pkg::mem_req_t  p1_i,
  output logic                      p1_gnt_o,
  output mem_region_pkg::mem_rsp_t  p1_rsp_o,

  // RAM side
  output logic                      ram_en_o,
  output mem_region_pkg::mem_req_t  ram_o,
  input  logic [`MR_DATA_WIDTH-1:0] ram_rdata_i
);

  logic valid_q;
  logic owner_q;

  // fixed priority with the loader winning
  always_comb
  begin
    p0_gnt_o = p0_req_i;
    p1_gnt_o = p1_req_i & ~p0_req_i;
    ram_en_o = p0_req_i | p1_req_i;
    ram_o    = p0_req_i ? p0_i : p1_i;
  end

  // owner of the data coming out of the RAM next cycle
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      valid_q <= 1'b0;
      owner_q <= 1'b0;
    end
    else
    begin
      valid_q <= ram_en_o;
      owner_q <= p1_gnt_o;
    end
  end

  always_comb
  begin
    p0_rsp_o.rvalid = valid_q & ~owner_q;
    p0_rsp_o.rdata  = ram_rdata_i;
    p1_rsp_o.rvalid = valid_q & owner_q;
    p1_rsp_o.rdata  = ram_rdata_i;
  end

  gnt_exclusive_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    !(p0_gnt_o && p1_gnt_o)
  ) else $error("both arbiter ports granted in one cycle");

  // each response must come from a RAM access one cycle before
  rvalid_after_en_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    (p0_rsp_o.rvalid || p1_rsp_o.rvalid) |-> $past(ram_en_o)
  ) else $error("rvalid without an enabled RAM cycle");

endmodule

//--- sp_ram.sv
`timescale 1ns/1ps

`include "mem_region_settings.svh"

module sp_ram (
  input  logic                          clk,
  input  logic                          en_i,
  input  logic [`MR_RAM_ADDR_WIDTH-1:0] addr_i,
  input  logic                          we_i,
  input  logic [`MR_BE_WIDTH-1:0]       be_i,
  input  logic [`MR_DATA_WIDTH-1:0]     wdata_i,
  output logic [`MR_DATA_WIDTH-1:0]     rdata_o
);

  logic [`MR_DATA_WIDTH-1:0] mem_q [0:(1 << `MR_RAM_ADDR_WIDTH)-1];

  // byte lane writes, registered read
  always_ff @(posedge clk)
  begin
    if (en_i)
    begin
      if (we_i)
      begin
        for (int i = 0; i < `MR_BE_WIDTH; i++)
        begin
          if (be_i[i])
          begin
            mem_q[addr_i][i*(`MR_DATA_WIDTH/`MR_BE_WIDTH) +: (`MR_DATA_WIDTH/`MR_BE_WIDTH)] <=
              wdata_i[i*(`MR_DATA_WIDTH/`MR_BE_WIDTH) +: (`MR_DATA_WIDTH/`MR_BE_WIDTH)];
          end
        end
      end
      else
      begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

//--- tb_mem_region.sv
`timescale 1ns/1ps

`include "mem_region_settings.svh"

module tb_mem_region;

  localparam int P_FETCH = 0;
  localparam int P_LSU   = 1;
  localparam int P_ILOAD = 2;
  localparam int P_DLOAD = 3;

  localparam int RAM_WORDS = 1 << `MR_RAM_ADDR_WIDTH;
  localparam int LANE_W    = `MR_DATA_WIDTH / `MR_BE_WIDTH;
  localparam logic [`MR_DATA_WIDTH-1:0] EXT_PATTERN = 32'h5a3c_96e1;

  // about 80 local accesses of 3 cycles and 8 external ones of up to 12
  localparam int N_LOCAL_OPS    = 80;
  localparam int N_EXT_OPS      = 8;
  localparam int TIMEOUT_CYCLES = 10 + 3 * N_LOCAL_OPS + 12 * N_EXT_OPS + 200;

  logic                     clk;
  logic                     rst_n;
  logic                     fetch_req_i;
  mem_region_pkg::mem_req_t fetch_i;
  logic                     fetch_gnt_o;
  mem_region_pkg::mem_rsp_t fetch_rsp_o;
  logic                     lsu_req_i;
  mem_region_pkg::mem_req_t lsu_i;
  logic                     lsu_gnt_o;
  mem_region_pkg::mem_rsp_t lsu_rsp_o;
  logic                     iload_req_i;
  mem_region_pkg::mem_req_t iload_i;
  logic                     iload_gnt_o;
  mem_region_pkg::mem_rsp_t iload_rsp_o;
  logic                     dload_req_i;
  mem_region_pkg::mem_req_t dload_i;
  logic                     dload_gnt_o;
  mem_region_pkg::mem_rsp_t dload_rsp_o;
  logic                     ext_req_o;
  mem_region_pkg::mem_req_t ext_o;
  logic                     ext_gnt_i;
  mem_region_pkg::mem_rsp_t ext_rsp_i;

  logic [`MR_DATA_WIDTH-1:0] imodel [0:RAM_WORDS-1];
  logic [`MR_DATA_WIDTH-1:0] dmodel [0:RAM_WORDS-1];
  logic [`MR_ADDR_WIDTH-1:0] daddr [0:7];
  logic [`MR_ADDR_WIDTH-1:0] iaddr [0:7];

  // delays for the external responder picked by the issuing task
  mem_region_pkg::mem_req_t ext_seen;
  int ext_seen_cnt;
  int ext_hold;
  int ext_lat;

  int err_cnt;
  int cycle_cnt;

  mem_region_top u_mem_region_top (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .fetch_req_i ( fetch_req_i ),
    .fetch_i     ( fetch_i     ),
    .fetch_gnt_o ( fetch_gnt_o ),
    .fetch_rsp_o ( fetch_rsp_o ),
    .lsu_req_i   ( lsu_req_i   ),
    .lsu_i       ( lsu_i       ),
    .lsu_gnt_o   ( lsu_gnt_o   ),
    .lsu_rsp_o   ( lsu_rsp_o   ),
    .iload_req_i ( iload_req_i ),
    .iload_i     ( iload_i     ),
    .iload_gnt_o ( iload_gnt_o ),
    .iload_rsp_o ( iload_rsp_o ),
    .dload_req_i ( dload_req_i ),
    .dload_i     ( dload_i     ),
    .dload_gnt_o ( dload_gnt_o ),
    .dload_rsp_o ( dload_rsp_o ),
    .ext_req_o   ( ext_req_o   ),
    .ext_o       ( ext_o       ),
    .ext_gnt_i   ( ext_gnt_i   ),
    .ext_rsp_i   ( ext_rsp_i   )
  );

  always #2 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout: no end of test after %0d cycles", cycle_cnt);
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped on timeout");
    end
  end

  // external slave with late grant and late rvalid
  initial
  begin
    ext_gnt_i    = 1'b0;
    ext_rsp_i    = '0;
    ext_seen     = '0;
    ext_seen_cnt = 0;
    forever
    begin
      @(negedge clk);
      if (ext_req_o && rst_n)
      begin
        repeat (ext_hold) @(posedge clk);
        @(posedge clk);
        ext_gnt_i <= 1'b1;
        @(negedge clk);
        ext_seen     = ext_o;
        ext_seen_cnt = ext_seen_cnt + 1;
        @(posedge clk);
        ext_gnt_i <= 1'b0;
        repeat (ext_lat) @(posedge clk);
        @(posedge clk);
        ext_rsp_i.rvalid <= 1'b1;
        ext_rsp_i.rdata  <= ext_seen.addr ^ EXT_PATTERN;
        @(posedge clk);
        ext_rsp_i <= '0;
      end
    end
  end

  task automatic expect_eq(input logic [127:0] got, input logic [127:0] exp, input string msg);
    if (got !== exp)
    begin
      err_cnt = err_cnt + 1;
      $display("CHECK FAILED at %0t ns: %s (got %0h, expected %0h)", $time, msg, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  function automatic int word_idx(input logic [`MR_ADDR_WIDTH-1:0] addr);
    return (addr >> 2) % RAM_WORDS;
  endfunction

  function automatic logic [`MR_DATA_WIDTH-1:0] merge_be(
    input logic [`MR_DATA_WIDTH-1:0] old,
    input logic [`MR_DATA_WIDTH-1:0] wdata,
    input logic [`MR_BE_WIDTH-1:0]   be
  );
    logic [`MR_DATA_WIDTH-1:0] res;
    res = old;
    for (int i = 0; i < `MR_BE_WIDTH; i++)
    begin
      if (be[i])
      begin
        res[i*LANE_W +: LANE_W] = wdata[i*LANE_W +: LANE_W];
      end
    end
    return res;
  endfunction

  function automatic mem_region_pkg::mem_req_t make_req(
    input logic [`MR_ADDR_WIDTH-1:0] addr,
    input logic                      we,
    input logic [`MR_BE_WIDTH-1:0]   be,
    input logic [`MR_DATA_WIDTH-1:0] wdata
  );
    mem_region_pkg::mem_req_t r;
    r.addr  = addr;
    r.we    = we;
    r.be    = be;
    r.wdata = wdata;
    return r;
  endfunction

  function automatic logic gnt_of(input int port);
    case (port)
      P_FETCH: return fetch_gnt_o;
      P_LSU:   return lsu_gnt_o;
      P_ILOAD: return iload_gnt_o;
      default: return dload_gnt_o;
    endcase
  endfunction

  function automatic mem_region_pkg::mem_rsp_t rsp_of(input int port);
    case (port)
      P_FETCH: return fetch_rsp_o;
      P_LSU:   return lsu_rsp_o;
      P_ILOAD: return iload_rsp_o;
      default: return dload_rsp_o;
    endcase
  endfunction

  // call right after a rising edge
  task automatic drive_port(input int port, input logic req, input mem_region_pkg::mem_req_t r);
    case (port)
      P_FETCH:
      begin
        fetch_req_i <= req;
        fetch_i     <= r;
      end
      P_LSU:
      begin
        lsu_req_i <= req;
        lsu_i     <= r;
      end
      P_ILOAD:
      begin
        iload_req_i <= req;
        iload_i     <= r;
      end
      default:
      begin
        dload_req_i <= req;
        dload_i     <= r;
      end
    endcase
  endtask

  // one full transfer on a port checked against the models
  task automatic issue(input int port, input mem_region_pkg::mem_req_t r,
                       output logic [`MR_DATA_WIDTH-1:0] rdata);
    logic                      is_ext;
    logic                      instr;
    logic                      is_read;
    int                        seen_before;
    logic [`MR_DATA_WIDTH-1:0] exp;
    mem_region_pkg::mem_rsp_t  rsp;
    is_ext      = (port == P_LSU) && (|r.addr[`MR_EXT_MSB:`MR_EXT_LSB]);
    instr       = (port == P_FETCH) || (port == P_ILOAD);
    is_read     = !r.we || (port == P_FETCH);
    seen_before = ext_seen_cnt;
    ext_hold    = $urandom_range(0, 3);
    ext_lat     = $urandom_range(0, 2);
    @(posedge clk);
    drive_port(port, 1'b1, r);
    forever
    begin
      @(negedge clk);
      if (port == P_LSU && is_ext)
      begin
        expect_eq(lsu_gnt_o, ext_gnt_i, "lsu grant follows external grant");
      end
      else if (port == P_LSU)
      begin
        expect_eq(ext_req_o, 1'b0, "no external request for a local address");
      end
      if (gnt_of(port))
      begin
        break;
      end
    end
    @(posedge clk);
    drive_port(port, 1'b0, r);
    @(negedge clk);
    rsp = rsp_of(port);
    if (is_ext)
    begin
      while (!rsp.rvalid)
      begin
        @(negedge clk);
        rsp = rsp_of(port);
      end
      expect_eq(ext_seen_cnt, seen_before + 1, "one request seen on the external port");
      expect_eq(ext_seen, r, "external request fields");
    end
    else
    begin
      expect_eq(rsp.rvalid, 1'b1, "rvalid one cycle after grant");
    end
    rdata = rsp.rdata;
    if (is_ext)
    begin
      exp = r.addr ^ EXT_PATTERN;
    end
    else
    begin
      exp = instr ? imodel[word_idx(r.addr)] : dmodel[word_idx(r.addr)];
    end
    if (is_read)
    begin
      expect_eq(rdata, exp, "read data");
    end
    else if (!is_ext && instr)
    begin
      imodel[word_idx(r.addr)] = merge_be(imodel[word_idx(r.addr)], r.wdata, r.be);
    end
    else if (!is_ext)
    begin
      dmodel[word_idx(r.addr)] = merge_be(dmodel[word_idx(r.addr)], r.wdata, r.be);
    end
  endtask

  task automatic reset_outputs_low;
    @(negedge clk);
    expect_eq(ext_req_o, 1'b0, "ext_req_o low after reset");
    expect_eq(fetch_rsp_o.rvalid, 1'b0, "fetch rvalid low after reset");
    expect_eq(lsu_rsp_o.rvalid, 1'b0, "lsu rvalid low after reset");
    expect_eq(iload_rsp_o.rvalid, 1'b0, "iload rvalid low after reset");
    expect_eq(dload_rsp_o.rvalid, 1'b0, "dload rvalid low after reset");
  endtask

  task automatic dload_write_read;
    logic [`MR_DATA_WIDTH-1:0] rd;
    for (int i = 0; i < 8; i++)
    begin
      daddr[i] = $urandom & 32'h00ff_fffc;
      issue(P_DLOAD, make_req(daddr[i], 1'b1, 4'hf, $urandom), rd);
    end
    for (int i = 0; i < 8; i++)
    begin
      issue(P_DLOAD, make_req(daddr[i], 1'b1, $urandom_range(0, 15), $urandom), rd);
    end
    for (int i = 0; i < 8; i++)
    begin
      issue(P_DLOAD, make_req(daddr[i], 1'b0, 4'hf, '0), rd);
    end
  endtask

  task automatic lsu_local_rw;
    logic [`MR_DATA_WIDTH-1:0] rd;
    for (int i = 0; i < 8; i++)
    begin
      issue(P_LSU, make_req(daddr[i], 1'b0, 4'hf, '0), rd);
    end
    for (int i = 0; i < 8; i++)
    begin
      issue(P_LSU, make_req(daddr[i], 1'b1, $urandom_range(0, 15), $urandom), rd);
    end
    for (int i = 0; i < 8; i++)
    begin
      issue(P_DLOAD, make_req(daddr[i], 1'b0, 4'hf, '0), rd);
      issue(P_LSU, make_req(daddr[i], 1'b0, 4'hf, '0), rd);
    end
  endtask

  task automatic lsu_external_rw;
    logic [`MR_DATA_WIDTH-1:0] rd;
    logic [`MR_ADDR_WIDTH-1:0] addr;
    for (int i = 0; i < 4; i++)
    begin
      // low bits alias a local word that must stay untouched
      addr = daddr[i];
      addr[`MR_EXT_MSB:`MR_EXT_LSB] = $urandom_range(1, 255);
      issue(P_LSU, make_req(addr, 1'b1, $urandom_range(0, 15), $urandom), rd);
      issue(P_LSU, make_req(addr, 1'b0, 4'hf, '0), rd);
    end
    for (int i = 0; i < 4; i++)
    begin
      issue(P_DLOAD, make_req(daddr[i], 1'b0, 4'hf, '0), rd);
    end
  endtask

  task automatic dbank_contention;
    logic [`MR_DATA_WIDTH-1:0] exp_a;
    logic [`MR_DATA_WIDTH-1:0] exp_b;
    exp_a = dmodel[word_idx(daddr[0])];
    exp_b = dmodel[word_idx(daddr[1])];
    @(posedge clk);
    dload_req_i <= 1'b1;
    dload_i     <= make_req(daddr[0], 1'b0, 4'hf, '0);
    lsu_req_i   <= 1'b1;
    lsu_i       <= make_req(daddr[1], 1'b0, 4'hf, '0);
    @(negedge clk);
    expect_eq(dload_gnt_o, 1'b1, "loader wins the data bank");
    expect_eq(lsu_gnt_o, 1'b0, "lsu held off by the loader");
    @(posedge clk);
    dload_req_i <= 1'b0;
    @(negedge clk);
    expect_eq(dload_rsp_o.rvalid, 1'b1, "loader rvalid after contention");
    expect_eq(dload_rsp_o.rdata, exp_a, "loader read data after contention");
    expect_eq(lsu_gnt_o, 1'b1, "lsu granted one cycle later");
    @(posedge clk);
    lsu_req_i <= 1'b0;
    @(negedge clk);
    expect_eq(lsu_rsp_o.rvalid, 1'b1, "lsu rvalid after contention");
    expect_eq(lsu_rsp_o.rdata, exp_b, "lsu read data after contention");
  endtask

  task automatic program_load_fetch;
    logic [`MR_DATA_WIDTH-1:0] rd;
    for (int i = 0; i < 8; i++)
    begin
      iaddr[i] = $urandom & 32'h0000_0ffc;
      issue(P_ILOAD, make_req(iaddr[i], 1'b1, 4'hf, $urandom), rd);
    end
    for (int i = 0; i < 8; i++)
    begin
      issue(P_FETCH, make_req(iaddr[i], 1'b0, 4'h0, '0), rd);
    end
    // write attempt on the fetch port is just a read
    issue(P_FETCH, make_req(iaddr[0], 1'b1, 4'hf, ~imodel[word_idx(iaddr[0])]), rd);
    issue(P_FETCH, make_req(iaddr[0], 1'b0, 4'hf, '0), rd);
    issue(P_ILOAD, make_req(iaddr[0], 1'b0, 4'hf, '0), rd);
  endtask

  initial
  begin
    void'($urandom(88177));
    err_cnt     = 0;
    cycle_cnt   = 0;
    ext_hold    = 0;
    ext_lat     = 0;
    clk         = 1'b0;
    rst_n       = 1'b0;
    fetch_req_i = 1'b0;
    fetch_i     = '0;
    lsu_req_i   = 1'b0;
    lsu_i       = '0;
    iload_req_i = 1'b0;
    iload_i     = '0;
    dload_req_i = 1'b0;
    dload_i     = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    reset_outputs_low();
    dload_write_read();
    lsu_local_rw();
    lsu_external_rw();
    dbank_contention();
    program_load_fetch();
    repeat (2) @(posedge clk);
    if (err_cnt == 0)
    begin
      $display("NO ERRORS");
    end
    else
    begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
